/* frodo_cfg.svh */
`ifndef FRODO_CFG_SVH
`define FRODO_CFG_SVH

// matrix geometry
`define FRODO_N 32'd1344
`define FRODO_A_STRIDE (32'd16 * `FRODO_N)   // one plane of A in hash memory
`define FRODO_SE_STRIDE (32'd8 * `FRODO_N)   // one plane of S/E in sp ram
`define FRODO_B_BASE (32'd64 * `FRODO_N)     // result matrix base in sp ram

// line limits of one tile pass
`define LINE_LAST 32'd340
`define LINE_SQUARE_END 32'd336
`define LINE_STATE_DROP 32'd338
`define LINE_WB_FIRST 32'd4
`define LINE_LOAD_END 32'd2

// address steps per line
`define HASH_LINE_STEP 32'd64
`define SP_LINE_STEP 32'd32

`endif

/* mem_types_pkg.sv */
package mem_types_pkg;

    typedef logic [63:0] word_t;
    typedef logic [31:0] addr_t;

    // everything the controller drives toward the rams
    typedef struct packed {
        addr_t addr_hash;
        addr_t addr_sp;
        addr_t addr_sp_2;   // write-back port
        logic  wen_sp;
        logic  wen_sp_2;
        logic  wen_hash;
        word_t data_adder;  // partial sum fed back into the array
    } mem_req_t;

endpackage

/* sched_pkg.sv */
package sched_pkg;

    typedef enum logic [2:0] {
        MODE_IDLE = 3'd0,
        MODE_AS   = 3'd1,
        MODE_SA   = 3'd2,
        MODE_SB   = 3'd3,
        MODE_BS   = 3'd4
    } mem_mode_t;

    typedef enum logic [3:0] {
        ST_FREE        = 4'd0,
        ST_AS_SQUARE   = 4'd1,
        ST_AS_SAVE     = 4'd2,
        ST_AS_WAITHASH = 4'd3,
        ST_SA_LOAD1    = 4'd4,
        ST_SA_LOAD2    = 4'd5,
        ST_SA_CALC1    = 4'd6,
        ST_SA_CALC2    = 4'd7,
        ST_SA_DONE     = 4'd8
    } sched_state_t;

    typedef struct packed {
        logic [1:0]  beat;  // position inside a 4-beat group
        logic [31:0] line;
    } tile_pos_t;

    typedef struct packed {
        sched_state_t state;
        sched_state_t prev_state;
        mem_mode_t    mode;       // latched on calc_init
        logic [9:0]   block_cnt;
        logic         bias_sel;   // second sa pass
    } sched_info_t;

    typedef struct packed {
        logic enable;
        logic state;       // 0 load, 1 compute
        logic mode;
        logic tp_select;
        logic tp_dir;
        logic tp_rst_sync;
    } array_ctl_t;

endpackage

/* tile_counter.sv */
`timescale 1ns/1ns
`include "frodo_cfg.svh"

module tile_counter (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 clear_all,
    input  logic                 clear_beat,
    input  logic                 count_en,
    output sched_pkg::tile_pos_t pos
);

    logic [1:0]           beat;
    mem_types_pkg::addr_t line;  // same width as the addresses it scales

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat <= 2'd0;
        end else if (clear_all || clear_beat) begin
            beat <= 2'd0;
        end else if (count_en) begin
            beat <= beat + 2'd1;
        end
    end

    // one line per 4-beat group
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line <= '0;
        end else if (clear_all) begin
            line <= '0;
        end else if (beat == 2'd3) begin
            if (line == `LINE_LAST) begin
                line <= '0;
            end else begin
                line <= line + 32'd1;
            end
        end
    end

    assign pos.beat = beat;
    assign pos.line = line;

    line_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        pos.line <= `LINE_LAST
    ) else $error("tile line ran past last line");

endmodule

/* mem_sched_fsm.sv */
`timescale 1ns/1ns
`include "frodo_cfg.svh"

module mem_sched_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   calc_init,
    input  logic                   hash_ready,
    input  sched_pkg::mem_mode_t   mem_mode,
    input  sched_pkg::tile_pos_t   pos,
    output sched_pkg::sched_info_t info,
    output logic                   block_init,
    output logic                   load_init,
    output logic                   count_en
);

    sched_pkg::mem_mode_t    mode;
    sched_pkg::sched_state_t state;
    sched_pkg::sched_state_t prev_state;
    sched_pkg::sched_state_t next_state;
    logic [9:0]              block_cnt;
    logic                    bias_sel;
    logic                    tile_done;
    logic                    load_done;

    assign tile_done = (pos.line == `LINE_LAST) && (pos.beat == 2'd3);
    assign load_done = (pos.line == `LINE_LOAD_END) && (pos.beat == 2'd2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode <= sched_pkg::MODE_IDLE;
        end else if (calc_init) begin
            mode <= mem_mode;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= sched_pkg::ST_FREE;
            prev_state <= sched_pkg::ST_FREE;
        end else begin
            state      <= next_state;
            prev_state <= state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            sched_pkg::ST_FREE: begin
                if (mode == sched_pkg::MODE_AS) begin
                    next_state = sched_pkg::ST_AS_SQUARE;
                end else if (mode == sched_pkg::MODE_SA) begin
                    next_state = sched_pkg::ST_SA_LOAD1;
                end
            end
            sched_pkg::ST_AS_SQUARE: begin
                if (pos.line == `LINE_SQUARE_END) next_state = sched_pkg::ST_AS_SAVE;
            end
            sched_pkg::ST_AS_SAVE: begin
                if (tile_done) next_state = sched_pkg::ST_AS_WAITHASH;
            end
            sched_pkg::ST_AS_WAITHASH: begin
                if (hash_ready) next_state = sched_pkg::ST_AS_SQUARE;
            end
            sched_pkg::ST_SA_LOAD1: begin
                if (load_done) next_state = sched_pkg::ST_SA_CALC1;
            end
            sched_pkg::ST_SA_LOAD2: begin
                if (load_done) next_state = sched_pkg::ST_SA_CALC2;
            end
            sched_pkg::ST_SA_CALC1: begin
                if (tile_done) next_state = sched_pkg::ST_SA_LOAD2;
            end
            sched_pkg::ST_SA_CALC2: begin
                if (tile_done) next_state = sched_pkg::ST_SA_DONE;
            end
            sched_pkg::ST_SA_DONE: next_state = sched_pkg::ST_SA_DONE;  // held until reset
            default: next_state = sched_pkg::ST_FREE;
        endcase
    end

    // entry into either load state
    assign load_init = (next_state == sched_pkg::ST_SA_LOAD1 && state != sched_pkg::ST_SA_LOAD1)
                    || (next_state == sched_pkg::ST_SA_LOAD2 && state != sched_pkg::ST_SA_LOAD2);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_init <= 1'b0;
        end else begin
            block_init <= (state == sched_pkg::ST_AS_WAITHASH
                           && next_state == sched_pkg::ST_AS_SQUARE)
                       || (state == sched_pkg::ST_SA_LOAD1
                           && next_state == sched_pkg::ST_SA_CALC1)
                       || (state == sched_pkg::ST_SA_LOAD2
                           && next_state == sched_pkg::ST_SA_CALC2);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            block_cnt <= 10'd0;
        end else if (calc_init) begin
            block_cnt <= 10'd0;
        end else if (state == sched_pkg::ST_AS_SAVE
                     && next_state == sched_pkg::ST_AS_WAITHASH) begin
            block_cnt <= block_cnt + 10'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bias_sel <= 1'b0;
        end else if (state == sched_pkg::ST_SA_LOAD1) begin
            bias_sel <= 1'b0;
        end else if (state == sched_pkg::ST_SA_LOAD2) begin
            bias_sel <= 1'b1;
        end
    end

    assign count_en = (mode == sched_pkg::MODE_AS)
                   || (state == sched_pkg::ST_SA_LOAD1) || (state == sched_pkg::ST_SA_LOAD2)
                   || (state == sched_pkg::ST_SA_CALC1) || (state == sched_pkg::ST_SA_CALC2);

    assign info.state      = state;
    assign info.prev_state = prev_state;
    assign info.mode       = mode;
    assign info.block_cnt  = block_cnt;
    assign info.bias_sel   = bias_sel;

    // a load entry and a block start would both clear the beat counter
    init_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load_init && block_init)
    ) else $error("load_init and block_init overlap");

endmodule

/* mem_addr_gen.sv */
`timescale 1ns/1ns
`include "frodo_cfg.svh"

module mem_addr_gen (
    input  sched_pkg::sched_info_t  info,
    input  sched_pkg::tile_pos_t    pos,
    input  mem_types_pkg::word_t    bram_data_sp,
    output mem_types_pkg::mem_req_t req
);

    logic                 half_flag;
    logic [1:0]           save_bias;    // wraps in 2 bits
    logic [1:0]           save_bias_w;
    logic [1:0]           calc_bias;
    mem_types_pkg::addr_t beat_w;
    mem_types_pkg::addr_t blk_base;
    mem_types_pkg::addr_t wb_line;
    mem_types_pkg::addr_t hash_addr;

    assign half_flag   = info.block_cnt[0];
    assign save_bias   = 2'd2 - pos.beat;
    assign save_bias_w = save_bias + 2'd2;
    assign calc_bias   = pos.beat - 2'd1;
    assign beat_w      = 32'(pos.beat);

    // result block origin with two half blocks per 512 words
    assign blk_base = `FRODO_B_BASE + 32'(info.block_cnt[9:1]) * 32'd512
                    + (half_flag ? 32'd64 : 32'd0);

    // write-back trails the stream by 4 lines or by 5 on beat 0
    assign wb_line = (pos.beat != 2'd0) ? pos.line - `LINE_WB_FIRST
                                        : pos.line - (`LINE_WB_FIRST + 32'd1);

    assign hash_addr = pos.line * `HASH_LINE_STEP + beat_w * `FRODO_A_STRIDE;

    always_comb begin
        req = '0;
        if (info.mode == sched_pkg::MODE_AS) begin
            case (info.state)
                sched_pkg::ST_AS_SQUARE: begin
                    req.addr_hash = hash_addr;
                    req.addr_sp   = pos.line * `SP_LINE_STEP + beat_w * `FRODO_SE_STRIDE
                                  + (half_flag ? 32'd4 * `FRODO_SE_STRIDE : 32'd0);
                end
                sched_pkg::ST_AS_SAVE: begin
                    req.addr_sp    = blk_base + 32'(save_bias) * 32'd128;
                    req.addr_sp_2  = blk_base + 32'(save_bias_w) * 32'd128;
                    req.data_adder = bram_data_sp;
                    req.wen_sp_2   = (pos.line == `LINE_LAST - 32'd1 && pos.beat != 2'd0)
                                  || (pos.line == `LINE_LAST && pos.beat == 2'd0);
                end
                default: ;
            endcase
        end else if (info.mode == sched_pkg::MODE_SA) begin
            case (info.state)
                sched_pkg::ST_SA_LOAD1, sched_pkg::ST_SA_LOAD2: begin
                    req.addr_sp = beat_w * `FRODO_SE_STRIDE
                                + ((info.state == sched_pkg::ST_SA_LOAD2)
                                   ? 32'd4 * `FRODO_SE_STRIDE : 32'd0);
                end
                sched_pkg::ST_SA_CALC1, sched_pkg::ST_SA_CALC2: begin
                    req.addr_hash = hash_addr;
                    req.addr_sp_2 = `FRODO_B_BASE + wb_line * `HASH_LINE_STEP
                                  + 32'(calc_bias) * `FRODO_A_STRIDE
                                  + (info.bias_sel ? 32'd4 * `FRODO_A_STRIDE : 32'd0);
                    if (pos.line == `LINE_WB_FIRST) begin
                        req.wen_sp_2 = (pos.beat != 2'd0);
                    end else if (pos.line > `LINE_WB_FIRST && pos.line < `LINE_LAST) begin
                        req.wen_sp_2 = 1'b1;
                    end else if (pos.line == `LINE_LAST) begin
                        req.wen_sp_2 = (pos.beat == 2'd0);  // last tail write
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* array_ctrl.sv */
`timescale 1ns/1ns
`include "frodo_cfg.svh"

module array_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   calc_init,
    input  logic                   block_init,
    input  sched_pkg::mem_mode_t   mem_mode,
    input  sched_pkg::sched_info_t info,
    input  sched_pkg::tile_pos_t   pos,
    input  mem_types_pkg::word_t   bram_data_sp,
    input  mem_types_pkg::word_t   bram_data_hash,
    output sched_pkg::array_ctl_t  ctl,
    output mem_types_pkg::word_t   data_left,
    output mem_types_pkg::word_t   data_right
);

    logic enable;
    logic sys_state;
    logic sys_mode;
    logic tp_select;
    logic tp_dir;
    logic tp_rst_sync;
    logic first_cycle;

    assign first_cycle = (info.prev_state != info.state);  // state entered this cycle

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
        end else begin
            case (info.state)
                sched_pkg::ST_SA_LOAD1, sched_pkg::ST_SA_LOAD2:
                    enable <= !(pos.beat != 2'd0 && pos.line == `LINE_LOAD_END);
                sched_pkg::ST_SA_CALC1, sched_pkg::ST_SA_CALC2: begin
                    if (first_cycle) enable <= 1'b1;
                end
                sched_pkg::ST_AS_WAITHASH: enable <= 1'b0;
                sched_pkg::ST_AS_SAVE:     enable <= 1'b1;
                sched_pkg::ST_AS_SQUARE: begin
                    if (pos.line == 32'd1 && pos.beat == 2'd1) enable <= 1'b1;  // pipe filled
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sys_mode <= 1'b0;
        end else if (calc_init) begin
            sys_mode <= (mem_mode == sched_pkg::MODE_AS) || (mem_mode == sched_pkg::MODE_SB);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sys_state <= 1'b0;
        end else begin
            case (info.state)
                sched_pkg::ST_AS_SQUARE: sys_state <= 1'b1;
                sched_pkg::ST_AS_SAVE: begin
                    if (pos.line == `LINE_STATE_DROP && pos.beat == 2'd3) sys_state <= 1'b0;
                end
                sched_pkg::ST_SA_LOAD1, sched_pkg::ST_SA_LOAD2: sys_state <= 1'b0;
                sched_pkg::ST_SA_CALC1, sched_pkg::ST_SA_CALC2: sys_state <= 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tp_rst_sync <= 1'b0;
        end else begin
            tp_rst_sync <= block_init;
        end
    end

    // ping-pong half flips at each group start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tp_select <= 1'b1;
        end else if (calc_init || block_init) begin
            tp_select <= 1'b1;
        end else if (pos.beat == 2'd0) begin
            tp_select <= ~tp_select;
        end
    end

    always_comb begin
        tp_dir = 1'b1;
        if (info.mode == sched_pkg::MODE_AS) begin
            tp_dir = 1'b0;  // push out upward
        end else if (info.mode == sched_pkg::MODE_SA) begin
            tp_dir = (info.state == sched_pkg::ST_SA_LOAD1)
                  || (info.state == sched_pkg::ST_SA_LOAD2);
        end
    end

    always_comb begin
        data_left  = '0;
        data_right = '0;
        case (info.state)
            sched_pkg::ST_AS_SQUARE: begin
                data_left  = bram_data_hash;
                data_right = bram_data_sp;
            end
            sched_pkg::ST_SA_LOAD1, sched_pkg::ST_SA_LOAD2: data_right = bram_data_sp;
            sched_pkg::ST_SA_CALC1, sched_pkg::ST_SA_CALC2: begin
                if (!first_cycle) data_left = bram_data_hash;
            end
            default: ;
        endcase
    end

    assign ctl = '{enable: enable, state: sys_state, mode: sys_mode, tp_select: tp_select,
                   tp_dir: tp_dir, tp_rst_sync: tp_rst_sync};

endmodule

/* mem_ctrl.sv */
`timescale 1ns/1ns

module mem_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    calc_init,
    input  logic                    hash_ready,
    input  sched_pkg::mem_mode_t    mem_mode,
    input  mem_types_pkg::word_t    bram_data_sp,
    input  mem_types_pkg::word_t    bram_data_hash,
    output mem_types_pkg::word_t    data_left,
    output mem_types_pkg::word_t    data_right,
    output mem_types_pkg::mem_req_t mem_req,
    output sched_pkg::array_ctl_t   array_ctl,
    output sched_pkg::sched_state_t current_state
);

    sched_pkg::tile_pos_t   pos;
    sched_pkg::sched_info_t info;
    logic                   block_init;
    logic                   load_init;
    logic                   count_en;

    tile_counter u_tile_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear_all  (calc_init || block_init),
        .clear_beat (load_init),
        .count_en   (count_en),
        .pos        (pos)
    );

    mem_sched_fsm u_mem_sched_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .calc_init  (calc_init),
        .hash_ready (hash_ready),
        .mem_mode   (mem_mode),
        .pos        (pos),
        .info       (info),
        .block_init (block_init),
        .load_init  (load_init),
        .count_en   (count_en)
    );

    mem_addr_gen u_mem_addr_gen (
        .info         (info),
        .pos          (pos),
        .bram_data_sp (bram_data_sp),
        .req          (mem_req)
    );

    array_ctrl u_array_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .calc_init      (calc_init),
        .block_init     (block_init),
        .mem_mode       (mem_mode),
        .info           (info),
        .pos            (pos),
        .bram_data_sp   (bram_data_sp),
        .bram_data_hash (bram_data_hash),
        .ctl            (array_ctl),
        .data_left      (data_left),
        .data_right     (data_right)
    );

    assign current_state = info.state;

endmodule

/* tb_mem_ctrl.sv */
`timescale 1ns/1ns
`include "frodo_cfg.svh"

module tb_mem_ctrl;

    localparam int CLK_PERIOD      = 100;
    localparam int TILE_CYCLES     = 4 * (`LINE_LAST + 1);
    localparam int MAX_HASH_WAIT   = 16;
    // 4 as blocks, two sa passes, slack for loads and resets
    localparam int WATCHDOG_CYCLES = 4 * (TILE_CYCLES + MAX_HASH_WAIT) + 2 * TILE_CYCLES + 500;

    logic                    clk;
    logic                    rst_n;
    logic                    calc_init;
    logic                    hash_ready;
    sched_pkg::mem_mode_t    mem_mode;
    mem_types_pkg::word_t    bram_data_sp;
    mem_types_pkg::word_t    bram_data_hash;
    mem_types_pkg::word_t    data_left;
    mem_types_pkg::word_t    data_right;
    mem_types_pkg::mem_req_t mem_req;
    sched_pkg::array_ctl_t   array_ctl;
    sched_pkg::sched_state_t current_state;

    // reference model registers
    sched_pkg::mem_mode_t    m_mode;
    logic                    m_sys_mode;
    sched_pkg::sched_state_t m_state;
    sched_pkg::sched_state_t m_prev;
    sched_pkg::sched_state_t n_state;
    logic [1:0]              m_beat;
    logic [31:0]             m_line;
    logic [9:0]              m_blk;
    logic                    m_binit;
    logic                    n_binit;
    logic                    n_load_init;
    logic                    n_count;

    integer                  seed = 32'h6fc3_024f;
    int                      wait_left;
    int                      error_count;
    sched_pkg::sched_state_t last_state;
    sched_pkg::sched_state_t state_trace[$];
    sched_pkg::sched_state_t sa_order[5] = '{sched_pkg::ST_SA_LOAD1, sched_pkg::ST_SA_CALC1,
                                             sched_pkg::ST_SA_LOAD2, sched_pkg::ST_SA_CALC2,
                                             sched_pkg::ST_SA_DONE};

    mem_ctrl u_mem_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .calc_init      (calc_init),
        .hash_ready     (hash_ready),
        .mem_mode       (mem_mode),
        .bram_data_sp   (bram_data_sp),
        .bram_data_hash (bram_data_hash),
        .data_left      (data_left),
        .data_right     (data_right),
        .mem_req        (mem_req),
        .array_ctl      (array_ctl),
        .current_state  (current_state)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic in_load(sched_pkg::sched_state_t s);
        return (s == sched_pkg::ST_SA_LOAD1) || (s == sched_pkg::ST_SA_LOAD2);
    endfunction

    function automatic logic in_calc(sched_pkg::sched_state_t s);
        return (s == sched_pkg::ST_SA_CALC1) || (s == sched_pkg::ST_SA_CALC2);
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_mode     = sched_pkg::MODE_IDLE;
            m_sys_mode = 1'b0;
            m_state    = sched_pkg::ST_FREE;
            m_prev     = sched_pkg::ST_FREE;
            m_beat     = 2'd0;
            m_line     = 32'd0;
            m_blk      = 10'd0;
            m_binit    = 1'b0;
        end else begin
            n_state = m_state;
            case (m_state)
                sched_pkg::ST_FREE: begin
                    if (m_mode == sched_pkg::MODE_AS) n_state = sched_pkg::ST_AS_SQUARE;
                    else if (m_mode == sched_pkg::MODE_SA) n_state = sched_pkg::ST_SA_LOAD1;
                end
                sched_pkg::ST_AS_SQUARE:
                    if (m_line == 32'd336) n_state = sched_pkg::ST_AS_SAVE;
                sched_pkg::ST_AS_SAVE:
                    if (m_line == 32'd340 && m_beat == 2'd3) n_state = sched_pkg::ST_AS_WAITHASH;
                sched_pkg::ST_AS_WAITHASH:
                    if (hash_ready) n_state = sched_pkg::ST_AS_SQUARE;
                sched_pkg::ST_SA_LOAD1:
                    if (m_line == 32'd2 && m_beat == 2'd2) n_state = sched_pkg::ST_SA_CALC1;
                sched_pkg::ST_SA_LOAD2:
                    if (m_line == 32'd2 && m_beat == 2'd2) n_state = sched_pkg::ST_SA_CALC2;
                sched_pkg::ST_SA_CALC1:
                    if (m_line == 32'd340 && m_beat == 2'd3) n_state = sched_pkg::ST_SA_LOAD2;
                sched_pkg::ST_SA_CALC2:
                    if (m_line == 32'd340 && m_beat == 2'd3) n_state = sched_pkg::ST_SA_DONE;
                default: ;
            endcase
            n_load_init = in_load(n_state) && (n_state != m_state);
            n_count     = (m_mode == sched_pkg::MODE_AS) || in_load(m_state) || in_calc(m_state);
            n_binit     = (m_state == sched_pkg::ST_AS_WAITHASH
                           && n_state == sched_pkg::ST_AS_SQUARE)
                       || (in_load(m_state) && in_calc(n_state));
            if (calc_init || m_binit) m_line = 32'd0;
            else if (m_beat == 2'd3) m_line = (m_line == 32'd340) ? 32'd0 : m_line + 32'd1;
            if (calc_init || m_binit || n_load_init) m_beat = 2'd0;
            else if (n_count) m_beat = m_beat + 2'd1;
            if (calc_init) m_blk = 10'd0;
            else if (m_state == sched_pkg::ST_AS_SAVE
                     && n_state == sched_pkg::ST_AS_WAITHASH) m_blk = m_blk + 10'd1;
            if (calc_init) begin
                m_mode     = mem_mode;
                m_sys_mode = (mem_mode == sched_pkg::MODE_AS)
                          || (mem_mode == sched_pkg::MODE_SB);
            end
            m_prev  = m_state;
            m_state = n_state;
            m_binit = n_binit;
        end
    end

    function automatic mem_types_pkg::mem_req_t expected_req();
        mem_types_pkg::mem_req_t r;
        logic [31:0]             beat_w;
        logic [31:0]             base;
        logic [1:0]              rd_step;
        logic [1:0]              wr_step;
        logic [1:0]              col;
        logic [31:0]             row;
        r       = '0;
        beat_w  = {30'd0, m_beat};
        base    = `FRODO_B_BASE + {23'd0, m_blk[9:1]} * 32'd512 + (m_blk[0] ? 32'd64 : 32'd0);
        rd_step = 2'd2 - m_beat;
        wr_step = 2'd0 - m_beat;  // 2 - beat + 2
        col     = m_beat - 2'd1;
        row     = (m_beat == 2'd0) ? m_line - 32'd5 : m_line - 32'd4;
        if (m_state == sched_pkg::ST_AS_SQUARE) begin
            r.addr_hash = m_line * 32'd64 + beat_w * `FRODO_A_STRIDE;
            r.addr_sp   = m_line * 32'd32 + beat_w * `FRODO_SE_STRIDE
                        + (m_blk[0] ? 32'd4 * `FRODO_SE_STRIDE : 32'd0);
        end else if (m_state == sched_pkg::ST_AS_SAVE) begin
            r.addr_sp    = base + {30'd0, rd_step} * 32'd128;
            r.addr_sp_2  = base + {30'd0, wr_step} * 32'd128;
            r.data_adder = bram_data_sp;
            r.wen_sp_2   = (m_line == 32'd339 && m_beat != 2'd0)
                        || (m_line == 32'd340 && m_beat == 2'd0);
        end else if (in_load(m_state)) begin
            r.addr_sp = beat_w * `FRODO_SE_STRIDE
                      + ((m_state == sched_pkg::ST_SA_LOAD2) ? 32'd4 * `FRODO_SE_STRIDE : 32'd0);
        end else if (in_calc(m_state)) begin
            r.addr_hash = m_line * 32'd64 + beat_w * `FRODO_A_STRIDE;
            r.addr_sp_2 = `FRODO_B_BASE + row * 32'd64 + {30'd0, col} * `FRODO_A_STRIDE
                        + ((m_state == sched_pkg::ST_SA_CALC2) ? 32'd4 * `FRODO_A_STRIDE : 32'd0);
            r.wen_sp_2  = (m_line == 32'd4 && m_beat != 2'd0)
                       || (m_line >= 32'd5 && m_line <= 32'd339)
                       || (m_line == 32'd340 && m_beat == 2'd0);
        end
        return r;
    endfunction

    task automatic value_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
        error_count++;
        $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        $display("tests failed");
        $fatal(1, "output mismatch");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else value_mismatch(name, got, exp);
    endtask

    task automatic compare_outputs();
        mem_types_pkg::mem_req_t exp_req;
        mem_types_pkg::word_t    exp_left;
        mem_types_pkg::word_t    exp_right;
        exp_req   = expected_req();
        exp_left  = '0;
        exp_right = '0;
        if (m_state == sched_pkg::ST_AS_SQUARE) begin
            exp_left  = bram_data_hash;
            exp_right = bram_data_sp;
        end else if (in_load(m_state)) begin
            exp_right = bram_data_sp;
        end else if (in_calc(m_state) && m_prev == m_state) begin
            exp_left = bram_data_hash;  // first calc cycle stays zero
        end
        check_value("current_state", current_state, m_state);
        check_value("mem_req.addr_hash", mem_req.addr_hash, exp_req.addr_hash);
        check_value("mem_req.addr_sp", mem_req.addr_sp, exp_req.addr_sp);
        check_value("mem_req.addr_sp_2", mem_req.addr_sp_2, exp_req.addr_sp_2);
        check_value("mem_req.wen_sp", mem_req.wen_sp, exp_req.wen_sp);
        check_value("mem_req.wen_sp_2", mem_req.wen_sp_2, exp_req.wen_sp_2);
        check_value("mem_req.wen_hash", mem_req.wen_hash, exp_req.wen_hash);
        check_value("mem_req.data_adder", mem_req.data_adder, exp_req.data_adder);
        check_value("data_left", data_left, exp_left);
        check_value("data_right", data_right, exp_right);
        check_value("array_ctl.mode", array_ctl.mode, m_sys_mode);
    endtask

    // check on the falling edge before driving the next inputs
    task automatic next_cycle();
        @(negedge clk);
        compare_outputs();
        if (current_state != last_state) begin
            state_trace.push_back(current_state);
            last_state = current_state;
        end
        calc_init      = 1'b0;
        bram_data_sp   = {$random(seed), $random(seed)};
        bram_data_hash = {$random(seed), $random(seed)};
        if (m_state == sched_pkg::ST_AS_WAITHASH) begin
            if (m_prev != sched_pkg::ST_AS_WAITHASH) begin
                wait_left = $unsigned($random(seed)) % MAX_HASH_WAIT;
            end
            if (wait_left == 0) begin
                hash_ready = 1'b1;
            end else begin
                hash_ready = 1'b0;
                wait_left--;
            end
        end else begin
            hash_ready = 1'b0;
        end
    endtask

    task automatic reset_dut();
        rst_n    = 1'b0;
        mem_mode = sched_pkg::MODE_IDLE;
        repeat (3) next_cycle();
        check_value("current_state", current_state, sched_pkg::ST_FREE);
        check_value("mem_req.wen_sp", mem_req.wen_sp, 1'b0);
        check_value("mem_req.wen_sp_2", mem_req.wen_sp_2, 1'b0);
        check_value("mem_req.wen_hash", mem_req.wen_hash, 1'b0);
        check_value("array_ctl.enable", array_ctl.enable, 1'b0);
        check_value("array_ctl.state", array_ctl.state, 1'b0);
        check_value("array_ctl.mode", array_ctl.mode, 1'b0);
        check_value("array_ctl.tp_rst_sync", array_ctl.tp_rst_sync, 1'b0);
        check_value("array_ctl.tp_select", array_ctl.tp_select, 1'b1);
        rst_n = 1'b1;
    endtask

    task automatic start_run(input sched_pkg::mem_mode_t mode);
        next_cycle();
        calc_init = 1'b1;
        mem_mode  = mode;
    endtask

    initial begin
        rst_n          = 1'b0;
        calc_init      = 1'b0;
        hash_ready     = 1'b0;
        mem_mode       = sched_pkg::MODE_IDLE;
        bram_data_sp   = '0;
        bram_data_hash = '0;
        error_count    = 0;
        wait_left      = 0;
        last_state     = sched_pkg::ST_FREE;

        reset_dut();
        start_run(sched_pkg::MODE_AS);
        while (!(m_blk == 10'd3 && m_state == sched_pkg::ST_AS_WAITHASH)) next_cycle();
        repeat (20) next_cycle();

        reset_dut();
        state_trace.delete();
        last_state = sched_pkg::ST_FREE;
        start_run(sched_pkg::MODE_SA);
        while (m_state != sched_pkg::ST_SA_DONE) next_cycle();
        repeat (8) next_cycle();
        check_value("state_trace.size", state_trace.size(), 5);
        for (int i = 0; i < 5; i++) begin
            check_value($sformatf("state_trace[%0d]", i), state_trace[i], sa_order[i]);
        end

        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* project.f */
+incdir+.
mem_types_pkg.sv
sched_pkg.sv
tile_counter.sv
mem_sched_fsm.sv
mem_addr_gen.sv
array_ctrl.sv
mem_ctrl.sv
tb_mem_ctrl.sv
